// ==== vga_defs.svh ====
`ifndef VGA_DEFS_SVH
`define VGA_DEFS_SVH

// horizontal timing in pixel clocks
`define VGA_H_ACTIVE 640
`define VGA_H_FRONT 16
`define VGA_H_SYNC 96
`define VGA_H_BACK 48

// vertical timing in lines
`define VGA_V_ACTIVE 480
`define VGA_V_FRONT 10
`define VGA_V_SYNC 2
`define VGA_V_BACK 33

// framebuffer is half the screen in both directions, 8 bpp
`define FB_WIDTH 320
`define FB_HEIGHT 240

`define BLOCK_PIX 32 // pixels per fetched block
`define BURST_LEN 16 // 16-bit words per burst, two pixels each
`define BLOCKS_PER_ROW 10 // FB_WIDTH / BLOCK_PIX

// apb register offsets
`define REG_CTRL 8'h00
`define REG_BASE 8'h04
`define REG_STATUS 8'h08

`endif

// ==== vga_pkg.sv ====
`include "vga_defs.svh"

package vga_pkg;

    // one memory word, even pixel in the high byte
    typedef logic [15:0] fb_word_t;

    typedef logic [7:0] pixel_t; // 8 bpp, no palette

    typedef logic [31:0] mem_addr_t; // word address on the memory bus

    // block number = fb row * 10 + column block, max 2399
    typedef logic [11:0] block_t;

    typedef logic [$clog2(`BURST_LEN)-1:0] beat_t; // word index inside a burst

    // burst fetch states, same sequence as the bus handshake
    typedef enum logic [2:0] {
        FS_IDLE,   // req raised here when a block is needed
        FS_ADDR,   // address presented, block recorded
        FS_WAIT,   // held while mem_wait is high
        FS_READ,   // one word per clock
        FS_FINISH  // req drops, done pulse
    } fetch_state_e;

endpackage

// ==== vga_buf_wr_if.sv ====
// write port from the fetch engine into the line buffers
interface vga_buf_wr_if;

    logic            we;    // one strobe per burst beat
    logic            sel;   // target buffer, low bit of the block
    vga_pkg::beat_t   waddr; // word index in the buffer
    vga_pkg::fb_word_t wdata;
    logic            done;  // burst complete, buffer now holds the block

    modport fetch (
        output we,
        output sel,
        output waddr,
        output wdata,
        output done
    );

    // line buffer side
    modport buffer (
        input we,
        input sel,
        input waddr,
        input wdata,
        input done
    );

endinterface

// ==== vga_timing.sv ====
`include "vga_defs.svh"

// counters run blanking first: front porch, sync, back porch, then active
// so counter zero (held while disabled) sits in vertical blanking
module vga_timing (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            enable,
    output logic            hsync,
    output logic            vsync,
    output logic            de,
    output logic            fb_byte,
    output vga_pkg::beat_t  word_idx,
    output vga_pkg::block_t cur_block,
    output vga_pkg::block_t pref_block
);
    localparam int H_BLANK = `VGA_H_FRONT + `VGA_H_SYNC + `VGA_H_BACK;
    localparam int H_TOTAL = H_BLANK + `VGA_H_ACTIVE; // 800
    localparam int V_BLANK = `VGA_V_FRONT + `VGA_V_SYNC + `VGA_V_BACK;
    localparam int V_TOTAL = V_BLANK + `VGA_V_ACTIVE; // 525

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       h_act;
    logic       v_act;
    logic [9:0] px;      // screen column in the active area
    logic [8:0] ly;      // screen line in the active area
    logic [8:0] fx;      // fb column
    logic [7:0] fy;      // fb row
    logic [7:0] next_fy; // fb row of the line shown next
    logic       row_end; // on the last block of the row
    vga_pkg::block_t blk;
    vga_pkg::block_t pref;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            h_cnt <= '0;
            v_cnt <= '0;
        end else if (!enable) begin
            h_cnt <= '0; // park in blanking
            v_cnt <= '0;
        end else if (h_cnt == 10'(H_TOTAL - 1)) begin
            h_cnt <= '0;
            v_cnt <= (v_cnt == 10'(V_TOTAL - 1)) ? '0 : v_cnt + 10'd1;
        end else begin
            h_cnt <= h_cnt + 10'd1;
        end
    end

    always_comb begin
        h_act = h_cnt >= 10'(H_BLANK);
        v_act = v_cnt >= 10'(V_BLANK);
        px = h_cnt - 10'(H_BLANK); // only meaningful while active
        ly = 9'(v_cnt - 10'(V_BLANK));
        fx = px[9:1]; // each fb pixel is 2x2 on screen
        fy = ly[8:1];
        blk = vga_pkg::block_t'((32'(fy) * `FB_WIDTH + 32'(fx)) / `BLOCK_PIX);
        row_end = (32'(fx) / `BLOCK_PIX) == `BLOCKS_PER_ROW - 1;
        // odd screen lines move on to the next fb row, wrapping at frame end
        if (!ly[0])
            next_fy = fy;
        else if (fy == 8'(`FB_HEIGHT - 1))
            next_fy = '0;
        else
            next_fy = fy + 8'd1;
        if (!v_act)
            pref = '0; // vblank, top of the next frame
        else if (!h_act)
            pref = vga_pkg::block_t'(32'(fy) * `BLOCKS_PER_ROW); // line about to start
        else if (row_end)
            pref = vga_pkg::block_t'(32'(next_fy) * `BLOCKS_PER_ROW);
        else
            pref = blk + 12'd1;
    end

    // everything leaves one clock after the counters so pixel data lines up
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hsync <= 1'b1; // active low
            vsync <= 1'b1;
            de <= 1'b0;
            fb_byte <= 1'b0;
            word_idx <= '0;
            cur_block <= '0;
            pref_block <= '0;
        end else begin
            hsync <= !(h_cnt >= 10'(`VGA_H_FRONT) && h_cnt < 10'(`VGA_H_FRONT + `VGA_H_SYNC));
            vsync <= !(v_cnt >= 10'(`VGA_V_FRONT) && v_cnt < 10'(`VGA_V_FRONT + `VGA_V_SYNC));
            de <= h_act && v_act;
            fb_byte <= fx[0]; // odd pixel, low byte
            word_idx <= fx[4:1];
            cur_block <= blk;
            pref_block <= pref;
        end
    end

endmodule

// ==== vga_bus_fetch.sv ====
`include "vga_defs.svh"

// burst fetch engine on the req/ack/wait memory bus
// always works one block ahead of the display
module vga_bus_fetch (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               enable,
    input  vga_pkg::mem_addr_t base,
    input  vga_pkg::block_t    pref_block,
    output logic               mem_req,
    input  logic               mem_ack,
    input  logic               mem_wait,
    output vga_pkg::mem_addr_t mem_addr,
    input  vga_pkg::fb_word_t  mem_rdata,
    vga_buf_wr_if.fetch        wr
);
    vga_pkg::fetch_state_e state;
    vga_pkg::fetch_state_e state_nx;
    vga_pkg::mem_addr_t    next_addr; // address of the wanted block
    vga_pkg::mem_addr_t    addr_q;    // held from grant to finish
    vga_pkg::mem_addr_t    last_addr; // last block fetched, as an address
    logic                  last_vld;
    logic                  sel_q;     // buffer for the burst in flight
    logic                  need;
    vga_pkg::beat_t        beat;

    // comparing addresses also catches a base change in vblank
    assign next_addr = base + vga_pkg::mem_addr_t'(pref_block) * `BURST_LEN;
    assign need = enable && (!last_vld || next_addr != last_addr);

    always_comb begin
        state_nx = state;
        case (state)
            vga_pkg::FS_IDLE: begin
                if (need && mem_ack)
                    state_nx = vga_pkg::FS_ADDR; // granted
            end
            vga_pkg::FS_ADDR: begin
                state_nx = vga_pkg::FS_WAIT;
            end
            vga_pkg::FS_WAIT: begin
                if (!mem_wait)
                    state_nx = vga_pkg::FS_READ;
            end
            vga_pkg::FS_READ: begin
                if (beat == vga_pkg::beat_t'(`BURST_LEN - 1))
                    state_nx = vga_pkg::FS_FINISH;
            end
            vga_pkg::FS_FINISH: begin
                state_nx = vga_pkg::FS_IDLE;
            end
            default: begin
                state_nx = vga_pkg::FS_IDLE;
            end
        endcase
    end

    // req asks in idle, then holds from grant through the last beat
    always_comb begin
        case (state)
            vga_pkg::FS_IDLE:   mem_req = need;
            vga_pkg::FS_FINISH: mem_req = 1'b0;
            default:            mem_req = 1'b1;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= vga_pkg::FS_IDLE;
            addr_q <= '0;
            sel_q <= 1'b0;
            last_vld <= 1'b0;
            beat <= '0;
        end else begin
            state <= state_nx;
            if (state == vga_pkg::FS_IDLE && state_nx == vga_pkg::FS_ADDR) begin
                addr_q <= next_addr;
                sel_q <= pref_block[0]; // block k lives in buffer k mod 2
            end
            if (state == vga_pkg::FS_ADDR)
                last_vld <= 1'b1;
            if (!enable)
                last_vld <= 1'b0; // next frame refetches from scratch
            if (state == vga_pkg::FS_READ)
                beat <= beat + 1'b1; // wraps back to 0 after the last beat
            else
                beat <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (state == vga_pkg::FS_ADDR)
            last_addr <= addr_q; // qualified by last_vld
    end

    assign mem_addr = addr_q; // stable from present-address until finish

    // beats go straight into the line buffer
    assign wr.we = state == vga_pkg::FS_READ;
    assign wr.sel = sel_q;
    assign wr.waddr = beat;
    assign wr.wdata = mem_rdata;
    assign wr.done = state == vga_pkg::FS_FINISH;

endmodule

// ==== vga_line_buffer.sv ====
`include "vga_defs.svh"

// ping-pong pair of block buffers, even blocks in 0 and odd blocks in 1
module vga_line_buffer #(
    parameter type word_t = vga_pkg::fb_word_t
) (
    input  logic            clk,
    input  logic            arst_n,
    vga_buf_wr_if.buffer    wr,
    input  vga_pkg::block_t cur_block,
    input  vga_pkg::beat_t  word_idx,
    input  logic            fb_byte,
    input  logic            de,
    output vga_pkg::pixel_t pixel,
    output logic            underrun
);
    localparam int PW = $bits(vga_pkg::pixel_t);
    localparam int WW = $bits(word_t);

    word_t           mem [2][`BURST_LEN];
    logic [1:0]      valid;      // buffer holds a complete burst
    vga_pkg::block_t prev_block; // block shown on the last active pixel
    word_t           rd_word;
    logic            rd_vld;

    always_ff @(posedge clk) begin
        if (wr.we)
            mem[wr.sel][wr.waddr] <= wr.wdata;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid <= '0;
            prev_block <= '0;
        end else begin
            if (de) begin
                prev_block <= cur_block;
                if (cur_block != prev_block)
                    valid[prev_block[0]] <= 1'b0; // display left that block
            end
            if (wr.we)
                valid[wr.sel] <= 1'b0; // being overwritten
            if (wr.done)
                valid[wr.sel] <= 1'b1;
        end
    end

    assign rd_word = mem[cur_block[0]][word_idx];
    assign rd_vld = valid[cur_block[0]];

    // even pixel is the high byte
    always_comb begin
        if (de && rd_vld)
            pixel = fb_byte ? rd_word[PW-1:0] : rd_word[WW-1 -: PW];
        else
            pixel = '0; // blank, or data not there in time
    end

    assign underrun = de && !rd_vld; // one pulse per starved pixel

endmodule

// ==== vga_apb_regs.sv ====
`include "vga_defs.svh"

// control and status registers, zero wait state apb
module vga_apb_regs (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [7:0]         paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    input  logic               underrun_evt,
    output logic               enable,
    output vga_pkg::mem_addr_t base
);
    logic wr_en;
    logic underrun_flag; // sticky

    assign wr_en = psel && penable && pwrite; // access phase only
    assign pready = 1'b1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            enable <= 1'b0;
            base <= '0;
            underrun_flag <= 1'b0;
        end else begin
            if (wr_en && paddr == `REG_CTRL)
                enable <= pwdata[0];
            if (wr_en && paddr == `REG_BASE)
                base <= pwdata; // word address of fb pixel 0
            // a new event wins over a clear in the same cycle
            if (underrun_evt)
                underrun_flag <= 1'b1;
            else if (wr_en && paddr == `REG_STATUS && pwdata[0])
                underrun_flag <= 1'b0; // write 1 to clear
        end
    end

    always_comb begin
        case (paddr)
            `REG_CTRL:   prdata = {31'b0, enable};
            `REG_BASE:   prdata = base;
            `REG_STATUS: prdata = {31'b0, underrun_flag};
            default:     prdata = '0; // unmapped
        endcase
    end

endmodule

// ==== vga_fb_top.sv ====
// framebuffer scan-out, apb config in, memory bursts in, vga out
module vga_fb_top (
    input  logic               clk,
    input  logic               arst_n,
    // apb register port
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [7:0]         paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    // memory bus
    output logic               mem_req,
    input  logic               mem_ack,
    input  logic               mem_wait,
    output vga_pkg::mem_addr_t mem_addr,
    input  vga_pkg::fb_word_t  mem_rdata,
    // display
    output logic               hsync,
    output logic               vsync,
    output logic               de,
    output vga_pkg::pixel_t    pixel
);
    logic               enable;
    logic               underrun;
    logic               fb_byte;
    vga_pkg::mem_addr_t base;
    vga_pkg::beat_t     word_idx;
    vga_pkg::block_t    cur_block;
    vga_pkg::block_t    pref_block;

    vga_buf_wr_if wr_if ();

    vga_apb_regs u_regs (
        .clk          (clk),
        .arst_n       (arst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .underrun_evt (underrun),
        .enable       (enable),
        .base         (base)
    );

    vga_timing u_timing (
        .clk        (clk),
        .arst_n     (arst_n),
        .enable     (enable),
        .hsync      (hsync),
        .vsync      (vsync),
        .de         (de),
        .fb_byte    (fb_byte),
        .word_idx   (word_idx),
        .cur_block  (cur_block),
        .pref_block (pref_block)
    );

    vga_bus_fetch u_fetch (
        .clk        (clk),
        .arst_n     (arst_n),
        .enable     (enable),
        .base       (base),
        .pref_block (pref_block),
        .mem_req    (mem_req),
        .mem_ack    (mem_ack),
        .mem_wait   (mem_wait),
        .mem_addr   (mem_addr),
        .mem_rdata  (mem_rdata),
        .wr         (wr_if.fetch)
    );

    vga_line_buffer #(
        .word_t (vga_pkg::fb_word_t)
    ) u_lbuf (
        .clk       (clk),
        .arst_n    (arst_n),
        .wr        (wr_if.buffer),
        .cur_block (cur_block),
        .word_idx  (word_idx),
        .fb_byte   (fb_byte),
        .de        (de),
        .pixel     (pixel),
        .underrun  (underrun)
    );

endmodule

// ==== tb_vga_fb.sv ====
`include "vga_defs.svh"

module tb_vga_fb;
    localparam int H_TOTAL = `VGA_H_ACTIVE + `VGA_H_FRONT + `VGA_H_SYNC + `VGA_H_BACK;
    localparam int V_TOTAL = `VGA_V_ACTIVE + `VGA_V_FRONT + `VGA_V_SYNC + `VGA_V_BACK;
    localparam int FRAME_CYC = H_TOTAL * V_TOTAL;
    localparam int LEAD_CYC = `VGA_V_FRONT * H_TOTAL; // enable to first vsync
    localparam int LINE_WAIT_CYC = (`VGA_V_SYNC + `VGA_V_BACK + 1) * H_TOTAL; // to first line end
    localparam int DISABLE_CYC = 1000;
    // frames 1..3 plus the underrun frame, two leads after enable, one line wait, margin for apb
    localparam int TIMEOUT_CYC = 4 * FRAME_CYC + 2 * LEAD_CYC + LINE_WAIT_CYC + DISABLE_CYC
                                 + 10000;

    logic clk = 1'b0;
    logic arst_n;
    logic psel, penable, pwrite, pready;
    logic [7:0] paddr;
    logic [31:0] pwdata, prdata;
    logic mem_req, mem_ack, mem_wait;
    vga_pkg::mem_addr_t mem_addr;
    vga_pkg::fb_word_t mem_rdata;
    logic hsync, vsync, de;
    vga_pkg::pixel_t pixel;

    int err_cnt = 0;
    int chk_cnt = 0;
    int cycles = 0;
    int force_wait = -1; // negative means random wait
    logic check_on = 1'b0;
    logic [31:0] exp_base = '0;
    int pix_count = 0;
    int row = 0;
    int col = 0;
    logic de_q = 1'b0;

    vga_fb_top i_vga_fb_top (.*);

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYC) begin
            $display("timeout: test did not finish within %0d clock cycles", TIMEOUT_CYC);
            $display("Verification failed");
            $finish;
        end
    end

    task automatic check_pixel(input vga_pkg::pixel_t got, input vga_pkg::pixel_t exp,
                               input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %0t: %s got %02h expected %02h", $time, what, got, exp);
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp, input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %0t: %s got %08h expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERROR %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // memory content, a function of the word address only
    function automatic vga_pkg::fb_word_t mem_word(input logic [31:0] addr);
        logic [31:0] prod;
        prod = {16'b0, addr[15:0]} * 32'h9E37 + 32'h1234;
        return prod[15:0];
    endfunction

    // screen (x, y) -> fb pixel, two pixels per word, even one in the high byte
    function automatic vga_pkg::pixel_t expected_pixel(input logic [31:0] base, input int x,
                                                       input int y);
        int fx;
        int idx;
        vga_pkg::fb_word_t w;
        fx = x / 2;
        idx = (y / 2) * `FB_WIDTH + fx;
        w = mem_word(base + 32'(idx / 2));
        return (fx % 2 == 1) ? w[7:0] : w[15:8];
    endfunction

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        @(posedge clk);
        #10;
        psel = 1'b1; // setup phase
        pwrite = 1'b1;
        paddr = addr;
        pwdata = data;
        @(posedge clk);
        #10;
        penable = 1'b1;
        @(negedge clk);
        check_bit(pready, 1'b1, "pready in write access phase"); // zero wait state
        @(posedge clk);
        #10;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
        @(posedge clk);
        #10;
        psel = 1'b1;
        paddr = addr;
        @(posedge clk);
        #10;
        penable = 1'b1;
        @(negedge clk);
        check_bit(pready, 1'b1, "pready in read access phase");
        data = prdata; // sampled mid access phase
        @(posedge clk);
        #10;
        psel = 1'b0;
        penable = 1'b0;
    endtask

    // returns at the negedge where vsync has just gone low
    task automatic wait_vsync();
        @(negedge clk);
        while (!vsync) @(negedge clk);
        while (vsync) @(negedge clk);
    endtask

    // one frame from vsync fall to vsync fall, pixels are compared alongside
    task automatic measure_frame();
        int hs_falls, hs_len, vs_len, de_len, de_lines;
        logic hs_q, vs_q, dq;
        hs_falls = 0;
        hs_len = 0;
        vs_len = 0;
        de_len = 0;
        de_lines = 0;
        hs_q = hsync;
        dq = de;
        do begin
            if (!vsync) vs_len++;
            if (!hsync) hs_len++;
            if (!hsync && hs_q) hs_falls++;
            if (hsync && !hs_q) begin
                check_word(hs_len, `VGA_H_SYNC, "hsync low width");
                hs_len = 0;
            end
            if (de) de_len++;
            if (!de && dq) begin
                check_word(de_len, `VGA_H_ACTIVE, "de high cycles in a line");
                de_lines++;
                de_len = 0;
            end
            hs_q = hsync;
            vs_q = vsync;
            dq = de;
            @(negedge clk);
        end while (!(!vsync && vs_q));
        check_word(hs_falls, V_TOTAL, "hsync pulses per frame");
        check_word(vs_len, `VGA_V_SYNC * H_TOTAL, "vsync low cycles");
        check_word(de_lines, `VGA_V_ACTIVE, "active lines per frame");
    endtask

    // display position tracking and pixel compare
    always @(negedge clk) begin
        if (!vsync) begin
            row = 0;
            col = 0;
        end else if (de) begin
            if (check_on) begin
                check_pixel(pixel, expected_pixel(exp_base, col, row),
                            $sformatf("pixel x=%0d y=%0d", col, row));
                pix_count++;
            end
            col++;
        end else if (de_q) begin
            row++; // line done
            col = 0;
        end
        de_q = de;
    end

    // req/ack/wait memory, ack after 0..3 cycles, then wait, then 16 beats
    initial begin : memory_model
        int gap;
        int wait_len;
        logic [31:0] addr;
        mem_ack = 1'b0;
        mem_wait = 1'b0;
        mem_rdata = '0;
        forever begin
            @(posedge clk);
            #10;
            if (mem_req) begin
                gap = $urandom_range(3, 0);
                repeat (gap) begin
                    @(posedge clk);
                    #10;
                end
                if (mem_req) begin // request may have gone away meanwhile
                    mem_ack = 1'b1;
                    @(posedge clk);
                    #10;
                    mem_ack = 1'b0; // granted, address is up now
                    addr = mem_addr;
                    if (force_wait >= 0) wait_len = force_wait;
                    else wait_len = $urandom_range(20, 0);
                    mem_wait = 1'b1;
                    @(posedge clk);
                    #10;
                    repeat (wait_len) begin
                        @(posedge clk);
                        #10;
                    end
                    mem_wait = 1'b0;
                    @(posedge clk);
                    #10;
                    for (int b = 0; b < `BURST_LEN; b++) begin
                        check_bit(mem_req, 1'b1, "mem_req held during burst");
                        check_word(mem_addr, addr, "mem_addr stable during burst");
                        mem_rdata = mem_word(addr + 32'(b));
                        @(posedge clk);
                        #10;
                    end
                end
            end
        end
    end

    initial begin : main
        logic [31:0] rd;
        logic [31:0] base_a;
        logic [31:0] base_b;
        void'($urandom(32'he29c));
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        #10;
        arst_n = 1'b1;
        @(negedge clk);
        check_bit(hsync, 1'b1, "hsync after reset"); // syncs idle high
        check_bit(vsync, 1'b1, "vsync after reset");
        check_bit(de, 1'b0, "de after reset");
        check_bit(mem_req, 1'b0, "mem_req after reset");
        check_pixel(pixel, '0, "pixel after reset");

        read_reg(`REG_STATUS, rd);
        check_word(rd, 32'd0, "STATUS after reset");
        read_reg(`REG_CTRL, rd);
        check_word(rd, 32'd0, "CTRL after reset");
        read_reg(`REG_BASE, rd);
        check_word(rd, 32'd0, "BASE after reset");
        base_a = $urandom() & 32'h00FF_FFFF;
        write_reg(`REG_BASE, base_a);
        read_reg(`REG_BASE, rd);
        check_word(rd, base_a, "BASE readback");
        read_reg(8'h0C, rd);
        check_word(rd, 32'd0, "unmapped offset 0x0C");
        read_reg(8'hFC, rd);
        check_word(rd, 32'd0, "unmapped offset 0xFC");
        exp_base = base_a;
        write_reg(`REG_CTRL, 32'd1); // scan-out starts here
        read_reg(`REG_CTRL, rd);
        check_word(rd, 32'd1, "CTRL readback");

        wait_vsync();
        pix_count = 0;
        check_on = 1'b1;
        measure_frame();
        wait_vsync();
        check_on = 1'b0;
        check_word(pix_count, 2 * `VGA_H_ACTIVE * `VGA_V_ACTIVE, "pixels seen in two frames");
        read_reg(`REG_STATUS, rd);
        check_word(rd, 32'd0, "STATUS after two clean frames");

        base_b = $urandom() & 32'h00FF_FFFF; // still in vblank here
        write_reg(`REG_BASE, base_b);
        exp_base = base_b;
        pix_count = 0;
        check_on = 1'b1;
        wait_vsync();
        check_on = 1'b0;
        check_word(pix_count, `VGA_H_ACTIVE * `VGA_V_ACTIVE, "pixels seen after base change");

        // stop scan-out in hblank right after an active line, no burst in flight there
        @(negedge clk);
        while (!de) @(negedge clk);
        while (de) @(negedge clk);
        write_reg(`REG_CTRL, 32'd0);
        repeat (DISABLE_CYC) begin
            @(negedge clk);
            check_bit(de, 1'b0, "de while disabled");
            check_pixel(pixel, '0, "pixel while disabled");
            check_bit(mem_req, 1'b0, "mem_req while disabled");
        end

        force_wait = 200; // far longer than a block is on screen
        write_reg(`REG_CTRL, 32'd1);
        wait_vsync();
        wait_vsync();
        read_reg(`REG_STATUS, rd);
        check_word(rd, 32'd1, "STATUS underrun flag");
        write_reg(`REG_CTRL, 32'd0);
        write_reg(`REG_STATUS, 32'd1);
        read_reg(`REG_STATUS, rd);
        check_word(rd, 32'd0, "STATUS after write-1 clear");

        $display("checks: %0d, errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+.
vga_pkg.sv
vga_buf_wr_if.sv
vga_timing.sv
vga_bus_fetch.sv
vga_line_buffer.sv
vga_apb_regs.sv
vga_fb_top.sv
tb_vga_fb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_vga_fb -f flist.f -o tb_vga_fb
./obj_dir/tb_vga_fb | tee sim.log

if grep -qx "Verification passed" sim.log; then
    echo "simulation PASS"
else
    echo "simulation FAIL"
    exit 1
fi
